// ==== list.f ====
+incdir+hw
hw/axi_pkg.sv
hw/axi_aw_channel.sv
hw/axi_burst_tracker.sv
hw/axi_w_channel.sv
hw/axi_b_channel.sv
hw/axi_write_protocol.sv
bench/tb_axi_write_protocol.sv

// ==== bench/tb_axi_write_protocol.sv ====
/*
 * testbench for the AXI write signal generator
 * directed tests for reset, single beats, bursts, W and B back-pressure
 * and address blocking while a burst is open
 */
`default_nettype none

`include "axi_defs.svh"

module tb_axi_write_protocol;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period = 4;
   localparam int num_tests  = 6;
   localparam axi_pkg::resp_t resp_okay = axi_pkg::resp_t'(`AXI_RESP_OKAY);

   logic            axi_aclk;
   logic            rst;
   axi_pkg::addr_t  awaddr_in, axi_awaddr;
   axi_pkg::len_t   awlen_in, axi_awlen;
   axi_pkg::size_t  awsize_in, axi_awsize;
   axi_pkg::burst_t awburst_in, axi_awburst;
   axi_pkg::data_t  wdata_in, axi_wdata;
   axi_pkg::strb_t  wstrb_in, axi_wstrb;
   axi_pkg::resp_t  axi_bresp;
   logic            awvalid_in, wvalid_in, wready_in, bready_in;
   logic            axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_wlast;
   logic            axi_bvalid, axi_bready;

   axi_write_protocol u_dut (.*);

   initial begin
      axi_aclk = 1'b0;
      forever #(clk_period / 2) axi_aclk = ~axi_aclk;
   end

   // #################### watchdog
   initial begin
      #(num_tests * 200 * clk_period + 100);   // 200 cycles per test plus margin
      $display("timeout: the DUT did not complete the tests in time");
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation timed out");
   end

   // #################### compare tasks
   task automatic fail_now(string msg);
      $display("FAILED @ %0t: %s", $time, msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_addr(string what, axi_pkg::addr_t got, axi_pkg::addr_t exp);
      if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
   endtask
   task automatic check_len(string what, axi_pkg::len_t got, axi_pkg::len_t exp);
      if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
   endtask
   task automatic check_size(string what, axi_pkg::size_t got, axi_pkg::size_t exp);
      if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
   endtask
   task automatic check_burst(string what, axi_pkg::burst_t got, axi_pkg::burst_t exp);
      if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
   endtask
   task automatic check_data(string what, axi_pkg::data_t got, axi_pkg::data_t exp);
      if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
   endtask
   task automatic check_strb(string what, axi_pkg::strb_t got, axi_pkg::strb_t exp);
      if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
   endtask
   task automatic check_resp(string what, axi_pkg::resp_t got, axi_pkg::resp_t exp);
      if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
   endtask
   task automatic check_bit(string what, logic got, logic exp);
      if (got !== exp) fail_now($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   // second address must sit on the bus without ready
   task automatic check_addr_held();
      check_bit("awvalid while blocked", axi_awvalid, 1'b1);
      check_bit("awready while blocked", axi_awready, 1'b0);
   endtask

   // #################### channel drivers
   task automatic drive_addr(axi_pkg::addr_t addr, axi_pkg::len_t len,
                             axi_pkg::size_t size, axi_pkg::burst_t burst);
      @(negedge axi_aclk);
      awaddr_in  = addr;
      awlen_in   = len;
      awsize_in  = size;
      awburst_in = burst;
      awvalid_in = 1'b1;                     // one-cycle strobe
      @(negedge axi_aclk);
      awvalid_in = 1'b0;
   endtask

   task automatic wait_addr(axi_pkg::addr_t addr, axi_pkg::len_t len,
                            axi_pkg::size_t size, axi_pkg::burst_t burst);
      while (!axi_awready) begin
         check_bit("awvalid before handshake", axi_awvalid, 1'b1);
         @(negedge axi_aclk);
      end
      check_bit("awvalid at handshake", axi_awvalid, 1'b1);
      check_addr("awaddr", axi_awaddr, addr);
      check_len("awlen", axi_awlen, len);
      check_size("awsize", axi_awsize, size);
      check_burst("awburst", axi_awburst, burst);
   endtask

   task automatic data_phase(axi_pkg::len_t len, int max_stall, bit blocked);
      axi_pkg::data_t data;
      axi_pkg::strb_t strb;
      int stall;
      int waited;
      for (int beat = 0; beat <= int'(len); beat++) begin
         data      = {$urandom, $urandom};
         strb      = axi_pkg::strb_t'($urandom);
         stall     = (max_stall > 0) ? $urandom_range(max_stall, 1) : 0;
         waited    = 0;
         wdata_in  = data;
         wstrb_in  = strb;
         wvalid_in = 1'b1;
         wready_in = (stall == 0);          // slave stalls this beat
         do begin
            @(negedge axi_aclk);
            wvalid_in = 1'b0;
            if (blocked) check_addr_held();
            check_bit("wvalid held", axi_wvalid, 1'b1);
            check_data("wdata", axi_wdata, data);
            check_strb("wstrb", axi_wstrb, strb);
            if (waited < stall) check_bit("wready during stall", axi_wready, 1'b0);
            waited++;
            if (waited >= stall) wready_in = 1'b1;
         end while (!axi_wready);
         check_bit("wlast", axi_wlast, beat == int'(len));   // last beat only
      end
   endtask

   task automatic resp_phase(int max_stall, bit blocked);
      int stall;
      int waited;
      stall     = (max_stall > 0) ? $urandom_range(max_stall, 1) : 0;
      waited    = 0;
      bready_in = (stall == 0);
      do begin
         @(negedge axi_aclk);
         if (blocked) check_addr_held();
         check_bit("wvalid after last beat", axi_wvalid, 1'b0);   // no repeated beat
         check_bit("bvalid", axi_bvalid, 1'b1);
         check_resp("bresp", axi_bresp, resp_okay);
         if (waited < stall) check_bit("bready during stall", axi_bready, 1'b0);
         waited++;
         if (waited >= stall) bready_in = 1'b1;
      end while (!axi_bready);
      @(negedge axi_aclk);
      check_bit("bvalid after handshake", axi_bvalid, 1'b0);
   endtask

   // #################### directed tests
   task automatic test_reset();
      check_bit("awvalid after reset", axi_awvalid, 1'b0);
      check_bit("awready after reset", axi_awready, 1'b1);
      check_bit("wvalid after reset", axi_wvalid, 1'b0);
      check_bit("wlast after reset", axi_wlast, 1'b0);
      check_bit("bvalid after reset", axi_bvalid, 1'b0);
      check_bit("bready after reset", axi_bready, 1'b0);
   endtask

   task automatic write_burst(axi_pkg::len_t len, int w_stall, int b_stall);
      axi_pkg::addr_t addr;
      addr = axi_pkg::addr_t'($urandom);
      drive_addr(addr, len, 3'd3, 2'd1);    // 8-byte beats, incr
      wait_addr(addr, len, 3'd3, 2'd1);
      data_phase(len, w_stall, 1'b0);
      resp_phase(b_stall, 1'b0);
   endtask

   task automatic test_addr_block();
      axi_pkg::addr_t first;
      axi_pkg::addr_t second;
      first  = axi_pkg::addr_t'($urandom);
      second = axi_pkg::addr_t'($urandom);
      drive_addr(first, 8'd1, 3'd3, 2'd1);
      wait_addr(first, 8'd1, 3'd3, 2'd1);
      drive_addr(second, 8'd2, 3'd2, 2'd2);   // issued inside the open burst
      data_phase(8'd1, 0, 1'b1);
      resp_phase(8, 1'b1);                     // held by the pending response
      wait_addr(second, 8'd2, 3'd2, 2'd2);
      data_phase(8'd2, 0, 1'b0);
      resp_phase(0, 1'b0);
   endtask

   initial begin
      void'($urandom(98));
      rst        = 1'b1;
      awaddr_in  = '0;
      awlen_in   = '0;
      awsize_in  = '0;
      awburst_in = '0;
      awvalid_in = 1'b0;
      wdata_in   = '0;
      wstrb_in   = '0;
      wvalid_in  = 1'b0;
      wready_in  = 1'b1;
      bready_in  = 1'b1;
      repeat (5) @(negedge axi_aclk);
      rst = 1'b0;
      test_reset();
      write_burst(8'd0, 0, 0);   // single beat
      write_burst(8'd3, 0, 0);   // four beats back to back
      write_burst(8'd3, 8, 0);   // W back-pressure
      test_addr_block();
      write_burst(8'd1, 0, 8);   // B back-pressure
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/axi_write_protocol.sv ====
/*
 * AXI write signal generator, top level
 * address, data and response channels plus the burst tracker
 */
`default_nettype none

module axi_write_protocol (
   input  wire                   axi_aclk,
   input  wire                   rst,
   // #################### address request
   input  wire axi_pkg::addr_t   awaddr_in,
   input  wire axi_pkg::len_t    awlen_in,
   input  wire axi_pkg::size_t   awsize_in,
   input  wire axi_pkg::burst_t  awburst_in,
   input  wire                   awvalid_in,
   output wire axi_pkg::addr_t   axi_awaddr,
   output wire axi_pkg::len_t    axi_awlen,
   output wire axi_pkg::size_t   axi_awsize,
   output wire axi_pkg::burst_t  axi_awburst,
   output wire                   axi_awvalid,
   output wire                   axi_awready,
   // #################### data
   input  wire axi_pkg::data_t   wdata_in,
   input  wire axi_pkg::strb_t   wstrb_in,
   input  wire                   wvalid_in,
   input  wire                   wready_in,
   output wire axi_pkg::data_t   axi_wdata,
   output wire axi_pkg::strb_t   axi_wstrb,
   output wire                   axi_wvalid,
   output wire                   axi_wready,
   output wire                   axi_wlast,
   // #################### response
   input  wire                   bready_in,
   output wire axi_pkg::resp_t   axi_bresp,
   output wire                   axi_bvalid,
   output wire                   axi_bready
);

   wire aw_commit;      // address handshake pulse
   wire w_commit;       // data handshake pulse
   wire burst_active;
   wire resp_pending;

   axi_aw_channel u_aw (
      .axi_aclk, .rst,
      .awaddr_in, .awlen_in, .awsize_in, .awburst_in, .awvalid_in,
      .burst_active, .resp_pending,
      .axi_awaddr, .axi_awlen, .axi_awsize, .axi_awburst,
      .axi_awvalid, .axi_awready, .aw_commit
   );

   axi_burst_tracker u_trk (
      .axi_aclk, .rst,
      .aw_commit, .axi_awlen, .w_commit,
      .burst_active, .axi_wlast
   );

   axi_w_channel u_w (
      .axi_aclk, .rst,
      .wdata_in, .wstrb_in, .wvalid_in, .wready_in,
      .burst_active, .axi_wlast,
      .axi_wdata, .axi_wstrb, .axi_wvalid, .axi_wready, .w_commit
   );

   axi_b_channel u_b (
      .axi_aclk, .rst,
      .w_commit, .axi_wlast, .bready_in,
      .axi_bresp, .axi_bvalid, .axi_bready, .resp_pending
   );

endmodule

`default_nettype wire

// ==== hw/axi_b_channel.sv ====
/*
 * AXI write-response channel
 * raises an OKAY response after the last beat, waits for bready and
 * flags the response as pending until its handshake
 */
`default_nettype none

`include "axi_defs.svh"

module axi_b_channel (
   input  wire            axi_aclk,
   input  wire            rst,
   input  wire            w_commit,
   input  wire            axi_wlast,
   input  wire            bready_in,       // master ready level
   output axi_pkg::resp_t axi_bresp,
   output logic           axi_bvalid,
   output logic           axi_bready,
   output logic           resp_pending     // blocks the next address
);

   logic                  last_beat;
   axi_pkg::chan_state_e  b_state;

   assign last_beat    = w_commit && axi_wlast;
   assign resp_pending = (b_state != axi_pkg::CH_WAIT);

   always_ff @(posedge axi_aclk) begin
      if (last_beat) begin
         axi_bresp <= axi_pkg::resp_t'(`AXI_RESP_OKAY);
      end
   end

   // #################### handshake fsm
   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         b_state    <= axi_pkg::CH_WAIT;
         axi_bvalid <= 1'b0;
         axi_bready <= 1'b0;
      end else begin
         axi_bready <= bready_in;   // one cycle behind
         case (b_state)
            axi_pkg::CH_WAIT: begin
               if (last_beat) begin
                  axi_bvalid <= 1'b1;
                  b_state    <= bready_in ? axi_pkg::CH_COMMIT : axi_pkg::CH_ASSERT;
               end
            end
            axi_pkg::CH_ASSERT: begin
               if (bready_in) begin
                  b_state <= axi_pkg::CH_COMMIT;
               end
            end
            axi_pkg::CH_COMMIT: begin
               axi_bvalid <= 1'b0;   // response consumed
               b_state    <= axi_pkg::CH_WAIT;
            end
            default: b_state <= axi_pkg::CH_WAIT;
         endcase
      end
   end

   // one response open at a time
   a_b_single: assert property (@(posedge axi_aclk) disable iff (rst)
      last_beat |-> b_state == axi_pkg::CH_WAIT);

endmodule

`default_nettype wire

// ==== hw/axi_w_channel.sv ====
/*
 * AXI write-data channel
 * registers each beat and strobe, holds them under back-pressure and
 * grants ready only inside an open burst
 */
`default_nettype none

module axi_w_channel (
   input  wire                  axi_aclk,
   input  wire                  rst,
   input  wire axi_pkg::data_t  wdata_in,
   input  wire axi_pkg::strb_t  wstrb_in,
   input  wire                  wvalid_in,     // one-cycle beat strobe
   input  wire                  wready_in,     // slave ready level
   input  wire                  burst_active,
   input  wire                  axi_wlast,
   output axi_pkg::data_t       axi_wdata,
   output axi_pkg::strb_t       axi_wstrb,
   output logic                 axi_wvalid,
   output logic                 axi_wready,
   output logic                 w_commit       // beat taken this cycle
);

   logic                  w_free;    // slave ready inside a burst
   logic                  w_load;
   axi_pkg::chan_state_e  w_state;

   assign w_free   = burst_active && wready_in;
   assign w_load   = wvalid_in && (w_state != axi_pkg::CH_ASSERT);
   assign w_commit = (w_state == axi_pkg::CH_COMMIT);

   always_ff @(posedge axi_aclk) begin
      if (w_load) begin
         axi_wdata <= wdata_in;
         axi_wstrb <= wstrb_in;
      end
   end

   // #################### handshake fsm
   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         w_state    <= axi_pkg::CH_WAIT;
         axi_wvalid <= 1'b0;
         axi_wready <= 1'b0;
      end else begin
         case (w_state)
            axi_pkg::CH_WAIT: begin
               axi_wready <= w_free;
               if (wvalid_in) begin
                  axi_wvalid <= 1'b1;
                  w_state    <= w_free ? axi_pkg::CH_COMMIT : axi_pkg::CH_ASSERT;
               end
            end
            axi_pkg::CH_COMMIT: begin
               axi_wvalid <= wvalid_in;
               if (axi_wlast) begin
                  axi_wready <= 1'b0;      // burst closes
                  w_state    <= wvalid_in ? axi_pkg::CH_ASSERT : axi_pkg::CH_WAIT;
               end else if (wvalid_in) begin
                  axi_wready <= w_free;    // back to back beats
                  w_state    <= w_free ? axi_pkg::CH_COMMIT : axi_pkg::CH_ASSERT;
               end else begin
                  axi_wready <= w_free;
                  w_state    <= axi_pkg::CH_WAIT;
               end
            end
            axi_pkg::CH_ASSERT: begin
               if (w_free) begin
                  axi_wready <= 1'b1;
                  w_state    <= axi_pkg::CH_COMMIT;
               end
            end
            default: w_state <= axi_pkg::CH_WAIT;
         endcase
      end
   end

   // stalled beat keeps its payload
   a_w_stable: assert property (@(posedge axi_aclk) disable iff (rst)
      axi_wvalid && !axi_wready |=> $stable(axi_wdata) && $stable(axi_wstrb));

endmodule

`default_nettype wire

// ==== hw/axi_burst_tracker.sv ====
/*
 * burst beat tracker
 * loads the accepted length, counts data beats, drives wlast and
 * the burst-active level
 */
`default_nettype none

module axi_burst_tracker (
   input  wire                 axi_aclk,
   input  wire                 rst,
   input  wire                 aw_commit,     // address handshake
   input  wire axi_pkg::len_t  axi_awlen,     // length of that address
   input  wire                 w_commit,      // data handshake
   output logic                burst_active,
   output logic                axi_wlast
);

   axi_pkg::len_t beats_left;   // beats after the current one

   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         burst_active <= 1'b0;
         axi_wlast    <= 1'b0;
      end else if (aw_commit) begin
         burst_active <= 1'b1;
         axi_wlast    <= (axi_awlen == '0);   // single beat burst
      end else if (w_commit) begin
         if (axi_wlast) begin
            burst_active <= 1'b0;             // last beat gone
            axi_wlast    <= 1'b0;
         end else if (beats_left == axi_pkg::len_t'(1)) begin
            axi_wlast    <= 1'b1;
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (aw_commit) begin
         beats_left <= axi_awlen;
      end else if (w_commit && !axi_wlast) begin
         beats_left <= beats_left - axi_pkg::len_t'(1);
      end
   end

   // data only moves inside an accepted burst
   a_w_in_burst: assert property (@(posedge axi_aclk) disable iff (rst)
      w_commit |-> burst_active);

endmodule

`default_nettype wire

// ==== hw/axi_aw_channel.sv ====
/*
 * AXI write-address channel
 * registers the requested burst fields and runs the handshake FSM,
 * holding the address off while a burst or its response is open
 */
`default_nettype none

module axi_aw_channel (
   input  wire                     axi_aclk,
   input  wire                     rst,
   input  wire axi_pkg::addr_t     awaddr_in,
   input  wire axi_pkg::len_t      awlen_in,
   input  wire axi_pkg::size_t     awsize_in,
   input  wire axi_pkg::burst_t    awburst_in,
   input  wire                     awvalid_in,    // one-cycle request strobe
   input  wire                     burst_active,
   input  wire                     resp_pending,
   output axi_pkg::addr_t          axi_awaddr,
   output axi_pkg::len_t           axi_awlen,
   output axi_pkg::size_t          axi_awsize,
   output axi_pkg::burst_t         axi_awburst,
   output logic                    axi_awvalid,
   output logic                    axi_awready,
   output logic                    aw_commit      // address taken this cycle
);

   logic                  aw_free;     // no burst and no response open
   logic                  aw_load;
   axi_pkg::chan_state_e  aw_state;

   assign aw_free   = !burst_active && !resp_pending;
   assign aw_load   = awvalid_in && (aw_state != axi_pkg::CH_ASSERT);
   assign aw_commit = (aw_state == axi_pkg::CH_COMMIT);

   // #################### field capture
   always_ff @(posedge axi_aclk) begin
      if (aw_load) begin
         axi_awaddr  <= awaddr_in;
         axi_awlen   <= awlen_in;
         axi_awsize  <= awsize_in;
         axi_awburst <= awburst_in;
      end
   end

   // #################### handshake fsm
   always_ff @(posedge axi_aclk) begin
      if (rst) begin
         aw_state    <= axi_pkg::CH_WAIT;
         axi_awvalid <= 1'b0;
         axi_awready <= 1'b1;
      end else begin
         case (aw_state)
            axi_pkg::CH_WAIT: begin
               if (awvalid_in) begin
                  axi_awvalid <= 1'b1;
                  axi_awready <= aw_free;
                  aw_state    <= aw_free ? axi_pkg::CH_COMMIT : axi_pkg::CH_ASSERT;
               end else begin
                  axi_awready <= aw_free;   // idle ready level
               end
            end
            axi_pkg::CH_COMMIT: begin
               axi_awready <= 1'b0;         // new burst opens next cycle
               axi_awvalid <= awvalid_in;
               aw_state    <= awvalid_in ? axi_pkg::CH_ASSERT : axi_pkg::CH_WAIT;
            end
            axi_pkg::CH_ASSERT: begin
               if (aw_free) begin
                  axi_awready <= 1'b1;
                  aw_state    <= axi_pkg::CH_COMMIT;
               end
            end
            default: aw_state <= axi_pkg::CH_WAIT;
         endcase
      end
   end

   // a pending address is never withdrawn
   a_aw_hold: assert property (@(posedge axi_aclk) disable iff (rst)
      axi_awvalid && !axi_awready |=> axi_awvalid);

endmodule

`default_nettype wire

// ==== hw/axi_pkg.sv ====
/*
 * types of the AXI write path
 * vector typedefs per field and the shared handshake state enum
 */
`default_nettype none

`include "axi_defs.svh"

package axi_pkg;

   typedef logic [`AXI_ADDR_W-1:0]  addr_t;    // write address
   typedef logic [`AXI_DATA_W-1:0]  data_t;    // data beat
   typedef logic [`AXI_STRB_W-1:0]  strb_t;    // byte enables
   typedef logic [`AXI_LEN_W-1:0]   len_t;     // beats minus one
   typedef logic [`AXI_SIZE_W-1:0]  size_t;    // beat size code
   typedef logic [`AXI_BURST_W-1:0] burst_t;   // burst type code
   typedef logic [`AXI_RESP_W-1:0]  resp_t;    // write response

   // one machine shape for every channel
   typedef enum logic [1:0] {
      CH_WAIT   = 2'b00,   // nothing on the bus
      CH_COMMIT = 2'b01,   // valid and ready both high
      CH_ASSERT = 2'b10    // valid held, ready low
   } chan_state_e;

endpackage

`default_nettype wire

// ==== hw/axi_defs.svh ====
/*
 * AXI write-path widths and response codes
 * shared by the type package and the response channel
 */
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// #################### field widths
`define AXI_ADDR_W    32   // write address
`define AXI_DATA_W    64   // one data beat
`define AXI_STRB_W    8    // byte enables per beat
`define AXI_LEN_W     8    // beats minus one
`define AXI_SIZE_W    3    // bytes per beat code
`define AXI_BURST_W   2    // fixed / incr / wrap
`define AXI_RESP_W    2    // bresp

// #################### response codes
`define AXI_RESP_OKAY 0    // normal access done

`endif
